/* filelist.f */
verilog/lcd_pkg.sv
verilog/game_pkg.sv
verilog/lcd_bus_owner.sv
verilog/frame_write_fsm.sv
verilog/pixel_scan_counter.sv
verilog/motion_timer.sv
verilog/sprite_mover.sv
verilog/pixel_composer.sv
verilog/lt24_frame_refresher.sv
tests/tb_lt24_frame_refresher.sv

/* Bender.yml */
package:
  name: lt24_frame_refresher

sources:
  - verilog/lcd_pkg.sv
  - verilog/game_pkg.sv
  - verilog/lcd_bus_owner.sv
  - verilog/frame_write_fsm.sv
  - verilog/pixel_scan_counter.sv
  - verilog/motion_timer.sv
  - verilog/sprite_mover.sv
  - verilog/pixel_composer.sv
  - verilog/lt24_frame_refresher.sv
  - target: simulation
    files:
      - tests/tb_lt24_frame_refresher.sv

/* tests/tb_lt24_frame_refresher.sv */
// lt24 frame refresher testbench for bus handover, setup words, frames and sprite motion
module tb_lt24_frame_refresher
	import lcd_pkg::*;
	import game_pkg::*;
();

	localparam int screen_w = 8;
	localparam int screen_h = 6;
	localparam int sprite_size = 2;
	localparam int tile_w = 4;
	localparam int tile_h = 3;
	localparam int tick_period = 200;
	// every word is a strobe-low and a strobe-high cycle
	localparam int frame_cycles = 2 * (7 + screen_w * screen_h);
	localparam int timeout_cycles = 6 * frame_cycles + 8 * tick_period + 200;

	logic clk = 1'b0;
	logic rst;
	lcd_bus_t cpu_bus;
	logic buffer_request;
	lcd_bus_t panel_bus;
	velocity_t vx;
	velocity_t vy;
	sprite_pos_t coin_start;
	sprite_pos_t coin_v;
	mem_req_t bg_req;
	pixel_t bg_data;
	mem_req_t sprite_req;
	pixel_t sprite_data;
	logic collision;
	sprite_pos_t character;
	sprite_pos_t coin;

	int seed = 74902;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int since_reset = 0;
	int last_write = -1;
	sprite_pos_t char_pos;
	lcd_word_t setup_words [7] = '{16'h002a, 16'h0000, 16'h0000, 16'h002b,
		16'h0000, 16'h0000, 16'h002c};

	lt24_frame_refresher #(
		.screen_w    (screen_w),
		.screen_h    (screen_h),
		.sprite_size (sprite_size),
		.tile_w      (tile_w),
		.tile_h      (tile_h),
		.tick_period (tick_period)
	) DUT (
		.clk            (clk),
		.rst            (rst),
		.cpu_bus        (cpu_bus),
		.buffer_request (buffer_request),
		.panel_bus      (panel_bus),
		.vx             (vx),
		.vy             (vy),
		.coin_start     (coin_start),
		.coin_v         (coin_v),
		.bg_req         (bg_req),
		.bg_data        (bg_data),
		.sprite_req     (sprite_req),
		.sprite_data    (sprite_data),
		.collision      (collision),
		.character      (character),
		.coin           (coin)
	);

	// combinational memory models that only answer an enabled request
	assign bg_data = bg_req.enable ? pixel_t'(bg_req.address) + 16'h0100 : 16'hxxxx;
	assign sprite_data = sprite_req.enable ? pixel_t'(sprite_req.address) + 16'h0500 : 16'hxxxx;

	always #50 clk = ~clk;

	// motion ticks land where since_reset reaches a multiple of tick_period
	always @(posedge clk)
	begin
		if (rst)
			since_reset <= 0;
		else
			since_reset <= since_reset + 1;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles)
		begin
			$display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	function automatic lcd_bus_t cpu_word(input logic [15:0] d, input logic cs_n,
		input logic wr_n, input logic rs);
		lcd_bus_t w;
		w.d = d;
		w.wr_n = wr_n;
		w.rd_n = 1'b1;
		w.cs_n = cs_n;
		w.reset_n = 1'b1;
		w.rs = rs;
		return w;
	endfunction

	// expected pixel from the priority and addressing rules
	function automatic pixel_t ref_colour(input int x, input int y, input sprite_pos_t ch,
		input sprite_pos_t co);
		logic on_ch;
		logic on_co;
		on_ch = (x >= ch.x) && (x < ch.x + sprite_size) && (y >= ch.y) && (y < ch.y + sprite_size);
		on_co = (x >= co.x) && (x < co.x + sprite_size) && (y >= co.y) && (y < co.y + sprite_size);
		if (on_ch && on_co)
			return 16'h0000;
		else if (on_ch)
			return 16'hf0ff;
		else if (on_co)
			return pixel_t'(16'h0500 + (x - co.x) + sprite_size * (y - co.y));
		return pixel_t'(16'h0100 + (x % tile_w) + tile_w * (y % tile_h));
	endfunction

	// cpu sends 0x2c in command phase and the request decides who owns the bus
	task take_bus(input logic request);
		@(posedge clk);
		cpu_bus <= cpu_word(16'h002c, 1'b0, 1'b0, 1'b0);
		buffer_request <= request;
		@(posedge clk);
		cpu_bus <= cpu_word(16'h0000, 1'b1, 1'b1, 1'b1);
		last_write = -1;
	endtask

	// waits for the next write word and checks the strobe shape and back-to-back spacing
	task capture_write(output lcd_bus_t w);
		@(negedge clk);
		while (panel_bus.wr_n)
			@(negedge clk);
		w = panel_bus;
		check_value("panel_bus.cs_n", w.cs_n, 1'b0);
		if (last_write >= 0)
			check_value("write spacing", since_reset - last_write, 2);
		last_write = since_reset;
		@(negedge clk);
		check_value("panel_bus.wr_n", panel_bus.wr_n, 1'b1);
		check_value("panel_bus.cs_n", panel_bus.cs_n, 1'b1);
	endtask

	task run_frame(input sprite_pos_t ch, input sprite_pos_t co);
		lcd_bus_t w;
		for (int i = 0; i < 7; i++)
		begin
			capture_write(w);
			check_value("setup panel_bus.d", w.d, setup_words[i]);
			check_value("setup panel_bus.rs", w.rs, (i % 3 == 0) ? 1'b0 : 1'b1);
		end
		for (int y = 0; y < screen_h; y++)
			for (int x = 0; x < screen_w; x++)
			begin
				capture_write(w);
				check_value("pixel panel_bus.d", w.d, ref_colour(x, y, ch, co));
				check_value("pixel panel_bus.rs", w.rs, 1'b1);
			end
	endtask

	task cpu_passthrough();
		lcd_bus_t w;
		logic [20:0] r;
		for (int i = 0; i < 8; i++)
		begin
			r = 21'($random(seed));
			w = r;
			@(posedge clk);
			cpu_bus <= w;
			@(negedge clk);
			check_value("panel_bus", panel_bus, w);
		end
		@(posedge clk);
		cpu_bus <= cpu_word(16'h0000, 1'b1, 1'b1, 1'b1);
	endtask

	// one motion tick with the given velocity starting at a fixed phase of the tick period
	task move_step(input velocity_t dx, input velocity_t dy, input int ex, input int ey);
		while (since_reset % tick_period != 10)
			@(negedge clk);
		@(posedge clk);
		vx <= dx;
		vy <= dy;
		do
			@(negedge clk);
		while (since_reset % tick_period != 10);
		check_value("character.x", character.x, ex);
		check_value("character.y", character.y, ey);
	endtask

	task motion_steps();
		// start point (10,10) lies off this small screen so the first tick clamps it
		move_step(0, 0, 6, 4);
		move_step(-4, -1, 2, 3);
		move_step(1, 0, 3, 3);
		move_step(1000, 0, 6, 3);
		move_step(-4, -2, 2, 1);
		@(posedge clk);
		vx <= 0;
		vy <= 0;
		char_pos = '{x: 11'd2, y: 11'd1};
	endtask

	task handover_frames();
		@(posedge clk);
		coin_start <= '{x: 11'd5, y: 11'd3};
		take_bus(1'b1);
		run_frame(char_pos, '{x: 11'd5, y: 11'd3});
		run_frame(char_pos, '{x: 11'd5, y: 11'd3});
		check_value("collision", collision, 1'b0);
	endtask

	task return_bus();
		take_bus(1'b0);
		@(negedge clk);
		@(negedge clk);
		check_value("panel_bus", panel_bus, cpu_word(16'h0000, 1'b1, 1'b1, 1'b1));
		check_value("collision", collision, 1'b0);
	endtask

	task collision_frame();
		@(posedge clk);
		coin_start <= '{x: 11'd3, y: 11'd2};
		take_bus(1'b1);
		run_frame(char_pos, '{x: 11'd3, y: 11'd2});
		check_value("collision", collision, 1'b1);
	endtask

	// coin at (3,2) steps by (2,2) per tick and wraps to sprite_size+1 once past the limit
	task coin_motion();
		while (since_reset % tick_period != 10)
			@(negedge clk);
		@(posedge clk);
		coin_v <= '{x: 11'd2, y: 11'd2};
		for (int i = 0; i < 2; i++)
		begin
			do
				@(negedge clk);
			while (since_reset % tick_period != 10);
			check_value("coin.x", coin.x, (i == 0) ? 5 : 3);
			check_value("coin.y", coin.y, (i == 0) ? 4 : 3);
		end
		@(posedge clk);
		coin_v <= '0;
	endtask

	initial
	begin
		rst = 1'b1;
		cpu_bus = cpu_word(16'h0000, 1'b1, 1'b1, 1'b1);
		buffer_request = 1'b0;
		vx = 0;
		vy = 0;
		coin_start = '0;
		coin_v = '0;
		repeat (8)
			@(posedge clk);
		rst <= 1'b0;

		cpu_passthrough();
		motion_steps();
		handover_frames();
		return_bus();
		collision_frame();
		coin_motion();
		return_bus();

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* verilog/lt24_frame_refresher.sv */
// lt24 frame refresher: takes the panel bus from the cpu and streams composed frames to it
module lt24_frame_refresher
	import lcd_pkg::*;
	import game_pkg::*;
#(
	parameter int screen_w    = 240,
	parameter int screen_h    = 320,
	parameter int sprite_size = 20,
	parameter int tile_w      = 60,
	parameter int tile_h      = 80,
	parameter int tick_period = 1048576
)
(
	input  logic        clk,
	input  logic        rst,
	input  lcd_bus_t    cpu_bus,
	input  logic        buffer_request,
	output lcd_bus_t    panel_bus,
	input  velocity_t   vx,
	input  velocity_t   vy,
	input  sprite_pos_t coin_start,
	input  sprite_pos_t coin_v,
	output mem_req_t    bg_req,
	input  pixel_t      bg_data,
	output mem_req_t    sprite_req,
	input  pixel_t      sprite_data,
	output logic        collision,
	output sprite_pos_t character,
	output sprite_pos_t coin
);

	logic owned;
	lcd_bus_t local_bus;
	logic advance;
	logic frame_start;
	logic frame_end;
	logic tick;
	sprite_pos_t pos;
	pixel_t colour;

	lcd_bus_owner u_owner (
		.clk            (clk),
		.rst            (rst),
		.cpu_bus        (cpu_bus),
		.buffer_request (buffer_request),
		.local_bus      (local_bus),
		.owned          (owned),
		.panel_bus      (panel_bus)
	);

	frame_write_fsm u_fsm (
		.clk         (clk),
		.rst         (rst),
		.owned       (owned),
		.frame_end   (frame_end),
		.colour      (colour),
		.local_bus   (local_bus),
		.advance     (advance),
		.frame_start (frame_start)
	);

	pixel_scan_counter #(
		.screen_w (screen_w),
		.screen_h (screen_h)
	) u_scan (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.advance     (advance),
		.pos         (pos),
		.frame_end   (frame_end)
	);

	motion_timer #(
		.tick_period (tick_period)
	) u_timer (
		.clk  (clk),
		.rst  (rst),
		.tick (tick)
	);

	sprite_mover #(
		.screen_w    (screen_w),
		.screen_h    (screen_h),
		.sprite_size (sprite_size)
	) u_mover (
		.clk        (clk),
		.rst        (rst),
		.owned      (owned),
		.tick       (tick),
		.vx         (vx),
		.vy         (vy),
		.coin_start (coin_start),
		.coin_v     (coin_v),
		.character  (character),
		.coin       (coin)
	);

	pixel_composer #(
		.sprite_size (sprite_size),
		.tile_w      (tile_w),
		.tile_h      (tile_h)
	) u_composer (
		.clk         (clk),
		.rst         (rst),
		.owned       (owned),
		.pos         (pos),
		.character   (character),
		.coin        (coin),
		.bg_req      (bg_req),
		.bg_data     (bg_data),
		.sprite_req  (sprite_req),
		.sprite_data (sprite_data),
		.colour      (colour),
		.collision   (collision)
	);

endmodule

/* verilog/pixel_composer.sv */
// pixel composer: sprite hit tests, memory addressing, colour priority and collision flag
module pixel_composer
	import game_pkg::*;
#(
	parameter int sprite_size = 20,
	parameter int tile_w      = 60,
	parameter int tile_h      = 80
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        owned,
	input  sprite_pos_t pos,
	input  sprite_pos_t character,
	input  sprite_pos_t coin,
	output mem_req_t    bg_req,
	input  pixel_t      bg_data,
	output mem_req_t    sprite_req,
	input  pixel_t      sprite_data,
	output pixel_t      colour,
	output logic        collision
);

	sprite_pos_t char_off;
	sprite_pos_t coin_off;
	logic in_char;
	logic in_coin;

	// offsets wrap when pos is left of or above the sprite, so check that first
	assign char_off.x = pos.x - character.x;
	assign char_off.y = pos.y - character.y;
	assign coin_off.x = pos.x - coin.x;
	assign coin_off.y = pos.y - coin.y;

	assign in_char = (pos.x >= character.x) && (char_off.x < coord_t'(sprite_size)) &&
		(pos.y >= character.y) && (char_off.y < coord_t'(sprite_size));
	assign in_coin = (pos.x >= coin.x) && (coin_off.x < coord_t'(sprite_size)) &&
		(pos.y >= coin.y) && (coin_off.y < coord_t'(sprite_size));

	// background tile repeats over the whole screen
	assign bg_req.address = 13'((pos.x % tile_w) + tile_w * (pos.y % tile_h));
	assign bg_req.enable = owned;
	assign sprite_req.address = 13'(coin_off.x + sprite_size * coin_off.y);
	assign sprite_req.enable = owned && in_coin;

	always_ff @(posedge clk)
	begin
		case ({in_char, in_coin})
			2'b11: colour <= overlap_colour;
			2'b10: colour <= character_colour;
			2'b01: colour <= sprite_data;
			default: colour <= bg_data;
		endcase
	end

	// sticky until the cpu takes the bus back
	always_ff @(posedge clk)
	begin
		if (rst || !owned)
			collision <= 1'b0;
		else if (in_char && in_coin)
			collision <= 1'b1;
	end

endmodule

/* verilog/sprite_mover.sv */
// sprite mover: steps the character with edge clamping and the coin with wrap-around
module sprite_mover
	import game_pkg::*;
#(
	parameter int screen_w    = 240,
	parameter int screen_h    = 320,
	parameter int sprite_size = 20
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        owned,
	input  logic        tick,
	input  velocity_t   vx,
	input  velocity_t   vy,
	input  sprite_pos_t coin_start,
	input  sprite_pos_t coin_v,
	output sprite_pos_t character,
	output sprite_pos_t coin
);

	localparam int lim_x = screen_w - sprite_size;
	localparam int lim_y = screen_h - sprite_size;

	// signed step, held inside [0, lim]
	function automatic coord_t clamp_step(coord_t p, velocity_t v, int lim);
		logic signed [32:0] s;
		s = $signed({22'b0, p}) + v;
		if (s < 0)
			return '0;
		else if (s > lim)
			return coord_t'(lim);
		else
			return s[10:0];
	endfunction

	// unsigned step, back near the top-left edge once past lim
	function automatic coord_t wrap_step(coord_t p, coord_t v, int lim);
		logic [11:0] s;
		s = {1'b0, p} + {1'b0, v};
		if (s > 12'(lim))
			return coord_t'(sprite_size + 1);
		else
			return s[10:0];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			character.x <= coord_t'(10);
			character.y <= coord_t'(10);
		end
		else if (tick)
		begin
			character.x <= clamp_step(character.x, vx, lim_x);
			character.y <= clamp_step(character.y, vy, lim_y);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			coin <= '0;
		else if (!owned)
			coin <= coin_start;
		else if (tick)
		begin
			coin.x <= wrap_step(coin.x, coin_v.x, lim_x);
			coin.y <= wrap_step(coin.y, coin_v.y, lim_y);
		end
	end

endmodule

/* verilog/motion_timer.sv */
// motion timer: wrapping cycle counter giving a one-cycle tick every tick_period cycles
module motion_timer #(
	parameter int tick_period = 1048576
)
(
	input  logic clk,
	input  logic rst,
	output logic tick
);

	localparam int cnt_w = (tick_period > 1) ? $clog2(tick_period) : 1;

	logic [cnt_w-1:0] cnt;

	assign tick = (cnt == cnt_w'(tick_period - 1));

	always_ff @(posedge clk)
	begin
		if (rst || tick)
			cnt <= '0;
		else
			cnt <= cnt + cnt_w'(1);
	end

endmodule

/* verilog/pixel_scan_counter.sv */
// pixel scan counter: column and row of the next pixel, with end-of-frame flag
module pixel_scan_counter
	import game_pkg::*;
#(
	parameter int screen_w = 240,
	parameter int screen_h = 320
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        frame_start,
	input  logic        advance,
	output sprite_pos_t pos,
	output logic        frame_end
);

	logic last_col;
	logic last_row;

	assign last_col = (pos.x == coord_t'(screen_w - 1));
	assign last_row = (pos.y == coord_t'(screen_h - 1));

	always_ff @(posedge clk)
	begin
		if (rst || frame_start)
		begin
			pos <= '0;
			frame_end <= 1'b0;
		end
		else if (advance)
		begin
			if (last_col)
			begin
				pos.x <= '0;
				if (last_row)
				begin
					pos.y <= '0;
					frame_end <= 1'b1;
				end
				else
					pos.y <= pos.y + coord_t'(1);
			end
			else
				pos.x <= pos.x + coord_t'(1);
		end
	end

endmodule

/* verilog/frame_write_fsm.sv */
// frame write FSM: cursor setup words, then pixel stream, each word as a strobe-low/strobe-high pair
module frame_write_fsm
	import lcd_pkg::*;
	import game_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     owned,
	input  logic     frame_end,
	input  pixel_t   colour,
	output lcd_bus_t local_bus,
	output logic     advance,
	output logic     frame_start
);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_pixel
	} state_t;

	state_t state;
	// low on the write half, high on the hold half
	logic hold;
	logic [2:0] setup_idx;

	always_ff @(posedge clk)
	begin
		if (rst || !owned)
		begin
			state <= st_idle;
			hold <= 1'b0;
			setup_idx <= 3'd0;
		end
		else
		begin
			hold <= !hold && (state != st_idle);
			case (state)
				st_idle:
				begin
					state <= st_setup;
					setup_idx <= 3'd0;
				end
				st_setup:
				begin
					if (hold && setup_idx == 3'(setup_len - 1))
						state <= st_pixel;
					else if (hold)
						setup_idx <= setup_idx + 3'd1;
				end
				default:
				begin
					// next frame starts straight after the last pixel
					if (hold && frame_end)
					begin
						state <= st_setup;
						setup_idx <= 3'd0;
					end
				end
			endcase
		end
	end

	assign advance = (state == st_pixel) && !hold;
	assign frame_start = owned && ((state == st_idle) || ((state == st_pixel) && hold && frame_end));

	always_comb
	begin
		local_bus.wr_n = (state == st_idle) || hold;
		local_bus.cs_n = (state == st_idle) || hold;
		local_bus.rd_n = 1'b1;
		local_bus.reset_n = 1'b1;
		local_bus.rs = 1'b1;
		local_bus.d = colour;
		if (state == st_setup)
		begin
			case (setup_idx)
				3'd0:
				begin
					local_bus.d = cmd_col_addr;
					local_bus.rs = 1'b0;
				end
				3'd3:
				begin
					local_bus.d = cmd_page_addr;
					local_bus.rs = 1'b0;
				end
				3'd6:
				begin
					local_bus.d = cmd_mem_write;
					local_bus.rs = 1'b0;
				end
				// start and end address bytes are all zero
				default:
					local_bus.d = '0;
			endcase
		end
	end

endmodule

/* verilog/lcd_bus_owner.sv */
// panel bus owner: watches the cpu for the memory-write command and routes the panel bus
module lcd_bus_owner
	import lcd_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  lcd_bus_t cpu_bus,
	input  logic     buffer_request,
	input  lcd_bus_t local_bus,
	output logic     owned,
	output lcd_bus_t panel_bus
);

	logic mem_write_cmd;

	// 0x2c in command phase with the panel selected
	assign mem_write_cmd = (cpu_bus.d == cmd_mem_write) && !cpu_bus.rs && !cpu_bus.cs_n;

	always_ff @(posedge clk)
	begin
		if (rst)
			owned <= 1'b0;
		else if (mem_write_cmd)
			owned <= buffer_request;
	end

	always_comb
	begin
		if (owned)
		begin
			panel_bus = local_bus;
			// the panel is never read back
			panel_bus.rd_n = 1'b1;
			// panel reset stays with the cpu
			panel_bus.reset_n = cpu_bus.reset_n;
		end
		else
			panel_bus = cpu_bus;
	end

endmodule

/* verilog/game_pkg.sv */
// game package: screen coordinates, sprite positions, memory requests and colours
package game_pkg;

	// screen coordinate, wide enough for 320 rows with headroom
	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} sprite_pos_t;

	// cpu-given velocity, two's complement
	typedef logic signed [31:0] velocity_t;

	// read request to a combinational on-chip memory
	typedef struct packed {
		logic [12:0] address;
		logic        enable;
	} mem_req_t;

	// rgb565 colour
	typedef logic [15:0] pixel_t;

	localparam pixel_t character_colour = 16'hf0ff;
	localparam pixel_t overlap_colour   = 16'h0000;

endpackage

/* verilog/lcd_pkg.sv */
// lcd panel bus package: 8080-style bus word layout and controller command codes
package lcd_pkg;

	// one 16-bit data word on the panel bus
	typedef logic [15:0] lcd_word_t;

	// full panel bus, 21 bits, strobes active low
	typedef struct packed {
		lcd_word_t d;
		logic      wr_n;
		logic      rd_n;
		logic      cs_n;
		logic      reset_n;
		// low for a command word, high for a data word
		logic      rs;
	} lcd_bus_t;

	// column and page address set, then memory write
	localparam lcd_word_t cmd_col_addr  = 16'h002a;
	localparam lcd_word_t cmd_page_addr = 16'h002b;
	localparam lcd_word_t cmd_mem_write = 16'h002c;

	// words sent to put the cursor at the origin before the pixels
	localparam int setup_len = 7;

endpackage
